// File: vec_pkg.sv
// Shared widths and encodings for the vector unit
// VLEN_ELEMS must be a multiple of NR_LANES and ELEM_W additions wrap
package vec_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned VLEN_ELEMS     = 16;
  localparam int unsigned ELEMS_PER_LANE = VLEN_ELEMS / NR_LANES;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEM_W         = 16;

  // Accept edge to done_o: issue slots, two lane stages, one reducer stage
  localparam int unsigned PIPE_LATENCY = ELEMS_PER_LANE + 3;

  ////////////////////
  // Data types
  ////////////////////

  // One element, also used for scalar operands and results
  typedef logic [ELEM_W-1:0] elem_t;

  typedef logic [$clog2(NR_VREGS)-1:0] vreg_idx_t;

  // Vector length 0..VLEN_ELEMS, also wide enough for an element index
  typedef logic [$clog2(VLEN_ELEMS+1)-1:0] vl_t;

  // Slot inside one lane, element e sits in slot e / NR_LANES
  typedef logic [$clog2(ELEMS_PER_LANE)-1:0] slot_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    VSPLAT   = 3'd0,
    VADD     = 3'd1,
    VADDS    = 3'd2,
    VREDSUM  = 3'd3,
    VEXTRACT = 3'd4
  } vec_op_e;

  // Sequencer walks IDLE -> ISSUE -> DRAIN -> IDLE
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    DRAIN = 2'd2
  } seq_state_e;

endpackage

// File: vec_sequencer.sv
// Holds one command at a time; cmd_valid_i while busy_o is high is dropped
// Command fields stay stable on the issue outputs until done_i
`timescale 1ns/1ps

module vec_sequencer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Command side
  input  logic                cmd_valid_i,
  input  vec_pkg::vec_op_e    cmd_op_i,
  input  vec_pkg::vreg_idx_t  cmd_vd_i,
  input  vec_pkg::vreg_idx_t  cmd_vs1_i,
  input  vec_pkg::vreg_idx_t  cmd_vs2_i,
  input  vec_pkg::vl_t        cmd_vl_i,
  input  vec_pkg::elem_t      cmd_scalar_i,
  // Completion from the reducer
  input  logic                done_i,
  output logic                busy_o,
  // Broadcast to the lanes
  output logic                issue_valid_o,
  output logic                issue_last_o,
  output vec_pkg::slot_t      issue_slot_o,
  output vec_pkg::vec_op_e    issue_op_o,
  output vec_pkg::vreg_idx_t  issue_vd_o,
  output vec_pkg::vreg_idx_t  issue_vs1_o,
  output vec_pkg::vreg_idx_t  issue_vs2_o,
  output vec_pkg::vl_t        issue_vl_o,
  output vec_pkg::elem_t      issue_scalar_o
);

  vec_pkg::seq_state_e state_q;
  vec_pkg::seq_state_e state_d;
  vec_pkg::slot_t      slot_q;

  // Held command
  vec_pkg::vec_op_e    op_q;
  vec_pkg::vl_t        vl_q;
  vec_pkg::vreg_idx_t  vd_q;
  vec_pkg::vreg_idx_t  vs1_q;
  vec_pkg::vreg_idx_t  vs2_q;
  vec_pkg::elem_t      scalar_q;

  logic accept;
  logic last_slot;

  assign accept    = cmd_valid_i && (state_q == vec_pkg::IDLE);
  assign last_slot = slot_q == vec_pkg::slot_t'(vec_pkg::ELEMS_PER_LANE - 1);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vec_pkg::IDLE: begin
        if (accept) begin
          state_d = vec_pkg::ISSUE;
        end
      end
      vec_pkg::ISSUE: begin
        if (last_slot) begin
          state_d = vec_pkg::DRAIN;
        end
      end
      vec_pkg::DRAIN: begin
        // Wait for the last slot to leave the reducer
        if (done_i) begin
          state_d = vec_pkg::IDLE;
        end
      end
      default: begin
        state_d = vec_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= vec_pkg::IDLE;
      slot_q  <= '0;
      op_q    <= vec_pkg::VSPLAT;
      vl_q    <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        slot_q <= '0;
        op_q   <= cmd_op_i;
        vl_q   <= cmd_vl_i;
      end else if (state_q == vec_pkg::ISSUE) begin
        slot_q <= slot_q + vec_pkg::slot_t'(1);
      end
    end
  end

  // Operand fields, held until the instruction completes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q     <= cmd_vd_i;
      vs1_q    <= cmd_vs1_i;
      vs2_q    <= cmd_vs2_i;
      scalar_q <= cmd_scalar_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign busy_o         = state_q != vec_pkg::IDLE;
  assign issue_valid_o  = state_q == vec_pkg::ISSUE;
  assign issue_last_o   = issue_valid_o && last_slot;
  assign issue_slot_o   = slot_q;
  assign issue_op_o     = op_q;
  assign issue_vd_o     = vd_q;
  assign issue_vs1_o    = vs1_q;
  assign issue_vs2_o    = vs2_q;
  assign issue_vl_o     = vl_q;
  assign issue_scalar_o = scalar_q;

endmodule

// File: vec_lane.sv
// One lane: element e lives here when e mod NR_LANES equals LANE_ID
// Issue fields must stay stable while the instruction drains
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Broadcast from the sequencer
  input  logic                issue_valid_i,
  input  logic                issue_last_i,
  input  vec_pkg::slot_t      issue_slot_i,
  input  vec_pkg::vec_op_e    issue_op_i,
  input  vec_pkg::vreg_idx_t  issue_vd_i,
  input  vec_pkg::vreg_idx_t  issue_vs1_i,
  input  vec_pkg::vreg_idx_t  issue_vs2_i,
  input  vec_pkg::vl_t        issue_vl_i,
  input  vec_pkg::elem_t      issue_scalar_i,
  // Per-slot result towards the reducer
  output logic                res_slot_valid_o,
  output logic                res_elem_valid_o,
  output logic                res_last_o,
  output vec_pkg::vec_op_e    res_op_o,
  output vec_pkg::elem_t      res_data_o
);

  // Register file slice, indexed by register then slot
  vec_pkg::elem_t rf_q [vec_pkg::NR_VREGS][vec_pkg::ELEMS_PER_LANE];

  vec_pkg::vl_t elem_idx;
  logic         in_range;
  logic         active;

  // Stage 1
  logic               s1_valid_q;
  logic               s1_last_q;
  logic               s1_active_q;
  vec_pkg::vec_op_e   s1_op_q;
  vec_pkg::slot_t     s1_slot_q;
  vec_pkg::vreg_idx_t s1_vd_q;
  vec_pkg::elem_t     s1_a_q;
  vec_pkg::elem_t     s1_b_q;

  // Stage 2
  vec_pkg::elem_t s2_data;
  logic           s2_write;

  ////////////////////
  // Stage 1 read
  ////////////////////

  assign elem_idx = vec_pkg::vl_t'(issue_slot_i) * vec_pkg::vl_t'(vec_pkg::NR_LANES)
                  + vec_pkg::vl_t'(LANE_ID);
  assign in_range = elem_idx < issue_vl_i;

  // Extract keeps only the one element it points at
  always_comb begin
    if (issue_op_i == vec_pkg::VEXTRACT) begin
      active = in_range && (vec_pkg::elem_t'(elem_idx) == issue_scalar_i);
    end else begin
      active = in_range;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q  <= 1'b0;
      s1_last_q   <= 1'b0;
      s1_active_q <= 1'b0;
      s1_op_q     <= vec_pkg::VSPLAT;
    end else begin
      s1_valid_q  <= issue_valid_i;
      s1_last_q   <= issue_valid_i && issue_last_i;
      s1_active_q <= issue_valid_i && active;
      if (issue_valid_i) begin
        s1_op_q <= issue_op_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    s1_slot_q <= issue_slot_i;
    s1_vd_q   <= issue_vd_i;
    s1_a_q    <= rf_q[issue_vs1_i][issue_slot_i];
    s1_b_q    <= rf_q[issue_vs2_i][issue_slot_i];
  end

  ////////////////////
  // Stage 2 execute
  ////////////////////

  // Scalar is still held by the sequencer at this point
  always_comb begin
    case (s1_op_q)
      vec_pkg::VSPLAT: s2_data = issue_scalar_i;
      vec_pkg::VADD:   s2_data = s1_a_q + s1_b_q;
      vec_pkg::VADDS:  s2_data = s1_a_q + issue_scalar_i;
      // Reductions and extract pass vs1 on
      default:         s2_data = s1_a_q;
    endcase
  end

  assign s2_write = s1_valid_q && s1_active_q
                 && (s1_op_q inside {vec_pkg::VSPLAT, vec_pkg::VADD, vec_pkg::VADDS});

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vec_pkg::NR_VREGS; r++) begin
        for (int s = 0; s < vec_pkg::ELEMS_PER_LANE; s++) begin
          rf_q[r][s] <= '0;
        end
      end
    end else if (s2_write) begin
      rf_q[s1_vd_q][s1_slot_q] <= s2_data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_slot_valid_o <= 1'b0;
      res_elem_valid_o <= 1'b0;
      res_last_o       <= 1'b0;
      res_op_o         <= vec_pkg::VSPLAT;
    end else begin
      res_slot_valid_o <= s1_valid_q;
      res_elem_valid_o <= s1_valid_q && s1_active_q;
      res_last_o       <= s1_last_q;
      res_op_o         <= s1_op_q;
    end
  end

  always_ff @(posedge clk_i) begin
    res_data_o <= s2_data;
  end

endmodule

// File: vec_reduce.sv
// Control comes from lane 0 only; all lanes run the same slots in lockstep
// result_o holds its last scalar value between scalar instructions
`timescale 1ns/1ps

module vec_reduce (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // Control from lane 0
  input  logic                                         res_slot_valid_i,
  input  logic                                         res_last_i,
  input  vec_pkg::vec_op_e                             res_op_i,
  // Data from every lane
  input  logic [vec_pkg::NR_LANES-1:0]                 res_elem_valid_i,
  input  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0]       res_data_i,
  input  vec_pkg::elem_t                               scalar_i,
  output logic                                         done_o,
  output logic                                         result_valid_o,
  output vec_pkg::elem_t                               result_o
);

  logic           first_q;
  logic           scalar_op;
  vec_pkg::elem_t acc_q;
  vec_pkg::elem_t base;
  vec_pkg::elem_t acc_d;

  assign scalar_op = (res_op_i == vec_pkg::VREDSUM) || (res_op_i == vec_pkg::VEXTRACT);

  // Seed on the first slot of an instruction
  always_comb begin
    if (!first_q) begin
      base = acc_q;
    end else if (res_op_i == vec_pkg::VREDSUM) begin
      base = scalar_i;
    end else begin
      base = '0;
    end
  end

  // Inactive lanes add nothing, so extract sees at most one value
  always_comb begin
    acc_d = base;
    for (int l = 0; l < vec_pkg::NR_LANES; l++) begin
      if (res_elem_valid_i[l]) begin
        acc_d = acc_d + res_data_i[l];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      first_q        <= 1'b1;
      acc_q          <= '0;
      done_o         <= 1'b0;
      result_valid_o <= 1'b0;
      result_o       <= '0;
    end else begin
      done_o         <= res_slot_valid_i && res_last_i;
      result_valid_o <= res_slot_valid_i && res_last_i && scalar_op;
      if (res_slot_valid_i) begin
        acc_q   <= acc_d;
        first_q <= res_last_i;
        if (res_last_i && scalar_op) begin
          result_o <= acc_d;
        end
      end
    end
  end

endmodule

// File: vec_unit.sv
// Top of the vector unit; one instruction in flight, done_o after PIPE_LATENCY
// No back-pressure beyond busy_o
`timescale 1ns/1ps

module vec_unit (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                cmd_valid_i,
  input  vec_pkg::vec_op_e    cmd_op_i,
  input  vec_pkg::vreg_idx_t  cmd_vd_i,
  input  vec_pkg::vreg_idx_t  cmd_vs1_i,
  input  vec_pkg::vreg_idx_t  cmd_vs2_i,
  input  vec_pkg::vl_t        cmd_vl_i,
  input  vec_pkg::elem_t      cmd_scalar_i,
  output logic                busy_o,
  output logic                done_o,
  output logic                result_valid_o,
  output vec_pkg::elem_t      result_o
);

  ////////////////////
  // Sequencer
  ////////////////////

  logic               issue_valid;
  logic               issue_last;
  vec_pkg::slot_t     issue_slot;
  vec_pkg::vec_op_e   issue_op;
  vec_pkg::vreg_idx_t issue_vd;
  vec_pkg::vreg_idx_t issue_vs1;
  vec_pkg::vreg_idx_t issue_vs2;
  vec_pkg::vl_t       issue_vl;
  vec_pkg::elem_t     issue_scalar;

  vec_sequencer u_seq (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .cmd_valid_i    (cmd_valid_i   ),
    .cmd_op_i       (cmd_op_i      ),
    .cmd_vd_i       (cmd_vd_i      ),
    .cmd_vs1_i      (cmd_vs1_i     ),
    .cmd_vs2_i      (cmd_vs2_i     ),
    .cmd_vl_i       (cmd_vl_i      ),
    .cmd_scalar_i   (cmd_scalar_i  ),
    .done_i         (done_o        ),
    .busy_o         (busy_o        ),
    .issue_valid_o  (issue_valid   ),
    .issue_last_o   (issue_last    ),
    .issue_slot_o   (issue_slot    ),
    .issue_op_o     (issue_op      ),
    .issue_vd_o     (issue_vd      ),
    .issue_vs1_o    (issue_vs1     ),
    .issue_vs2_o    (issue_vs2     ),
    .issue_vl_o     (issue_vl      ),
    .issue_scalar_o (issue_scalar  )
  );

  ////////////////////
  // Lanes
  ////////////////////

  logic [vec_pkg::NR_LANES-1:0]           res_slot_valid;
  logic [vec_pkg::NR_LANES-1:0]           res_elem_valid;
  logic [vec_pkg::NR_LANES-1:0]           res_last;
  vec_pkg::vec_op_e                       res_op [vec_pkg::NR_LANES];
  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0] res_data;

  for (genvar l = 0; l < vec_pkg::NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) u_lane (
      .clk_i            (clk_i            ),
      .arst_n_i         (arst_n_i         ),
      .issue_valid_i    (issue_valid      ),
      .issue_last_i     (issue_last       ),
      .issue_slot_i     (issue_slot       ),
      .issue_op_i       (issue_op         ),
      .issue_vd_i       (issue_vd         ),
      .issue_vs1_i      (issue_vs1        ),
      .issue_vs2_i      (issue_vs2        ),
      .issue_vl_i       (issue_vl         ),
      .issue_scalar_i   (issue_scalar     ),
      .res_slot_valid_o (res_slot_valid[l]),
      .res_elem_valid_o (res_elem_valid[l]),
      .res_last_o       (res_last[l]      ),
      .res_op_o         (res_op[l]        ),
      .res_data_o       (res_data[l]      )
    );
  end : gen_lanes

  ////////////////////
  // Reducer
  ////////////////////

  // Lane 0 stands in for the lockstep control of all lanes
  vec_reduce u_red (
    .clk_i            (clk_i            ),
    .arst_n_i         (arst_n_i         ),
    .res_slot_valid_i (res_slot_valid[0]),
    .res_last_i       (res_last[0]      ),
    .res_op_i         (res_op[0]        ),
    .res_elem_valid_i (res_elem_valid   ),
    .res_data_i       (res_data         ),
    .scalar_i         (issue_scalar     ),
    .done_o           (done_o           ),
    .result_valid_o   (result_valid_o   ),
    .result_o         (result_o         )
  );

endmodule

// File: vec_unit_checker.sv
// Timing properties of the vector unit top level
// All checks are off while arst_n_i is low
`timescale 1ns/1ps

module vec_unit_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic cmd_valid_i,
  input logic busy_i,
  input logic done_i,
  input logic result_valid_i
);

  logic accept;

  assign accept = cmd_valid_i && !busy_i;

  // One done pulse, PIPE_LATENCY cycles after the accepting edge
  done_latency_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    accept |-> ##(vec_pkg::PIPE_LATENCY) done_i ##1 !done_i
  ) else $error("done_o is not a single pulse at the expected latency");

  result_with_done_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    result_valid_i |-> done_i
  ) else $error("result_valid_o is high without done_o");

  // Unit is free again right after completion
  busy_release_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    done_i |=> !busy_i
  ) else $error("busy_o is still high the cycle after done_o");

endmodule

// File: tb_clkgen.sv
// Free-running 20 ns clock; reset held low until the second rising edge
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  // Half of the 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Two cycles of reset, released on a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: tb_vec_unit.sv
// Self-checking testbench for vec_unit, one command in flight at a time
// Stimulus keeps vl within 0..VLEN_ELEMS
`timescale 1ns/1ps

module tb_vec_unit;

  // Upper bound on the commands issued below
  localparam int unsigned NR_CMDS     = 340;
  localparam int unsigned CYCLE_LIMIT = NR_CMDS * (vec_pkg::PIPE_LATENCY + 4) + 100;

  logic               clk;
  logic               arst_n;
  logic               cmd_valid;
  vec_pkg::vec_op_e   cmd_op;
  vec_pkg::vreg_idx_t cmd_vd;
  vec_pkg::vreg_idx_t cmd_vs1;
  vec_pkg::vreg_idx_t cmd_vs2;
  vec_pkg::vl_t       cmd_vl;
  vec_pkg::elem_t     cmd_scalar;
  logic               busy;
  logic               done;
  logic               result_valid;
  vec_pkg::elem_t     result;

  // Reference register file, by register then element
  vec_pkg::elem_t model_rf [vec_pkg::NR_VREGS][vec_pkg::VLEN_ELEMS];

  // Expected outcome per issued command
  vec_pkg::elem_t exp_result_q [$];
  logic           exp_scalar_q [$];
  vec_pkg::elem_t exp_res;
  logic           exp_sc;

  int unsigned value_errs = 0;
  int unsigned other_errs = 0;
  int unsigned nr_issued  = 0;
  int unsigned nr_done    = 0;
  int unsigned cycle_cnt  = 0;

  tb_clkgen u_clkgen (
    .clk_o    (clk   ),
    .arst_n_o (arst_n)
  );

  vec_unit UUT (
    .clk_i          (clk         ),
    .arst_n_i       (arst_n      ),
    .cmd_valid_i    (cmd_valid   ),
    .cmd_op_i       (cmd_op      ),
    .cmd_vd_i       (cmd_vd      ),
    .cmd_vs1_i      (cmd_vs1     ),
    .cmd_vs2_i      (cmd_vs2     ),
    .cmd_vl_i       (cmd_vl      ),
    .cmd_scalar_i   (cmd_scalar  ),
    .busy_o         (busy        ),
    .done_o         (done        ),
    .result_valid_o (result_valid),
    .result_o       (result      )
  );

  bind vec_unit vec_unit_checker u_checker (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .cmd_valid_i    (cmd_valid_i   ),
    .busy_i         (busy_o        ),
    .done_i         (done_o        ),
    .result_valid_i (result_valid_o)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Updates model_rf and returns the scalar result of the command
  function automatic vec_pkg::elem_t ref_exec(
    input vec_pkg::vec_op_e op, input vec_pkg::vreg_idx_t vd, input vec_pkg::vreg_idx_t vs1,
    input vec_pkg::vreg_idx_t vs2, input vec_pkg::vl_t vl, input vec_pkg::elem_t scalar);
    vec_pkg::elem_t acc;
    acc = (op == vec_pkg::VREDSUM) ? scalar : '0;
    for (int e = 0; e < int'(vl); e++) begin
      case (op)
        vec_pkg::VSPLAT:  model_rf[vd][e] = scalar;
        vec_pkg::VADD:    model_rf[vd][e] = model_rf[vs1][e] + model_rf[vs2][e];
        vec_pkg::VADDS:   model_rf[vd][e] = model_rf[vs1][e] + scalar;
        vec_pkg::VREDSUM: acc = acc + model_rf[vs1][e];
        default: ;
      endcase
    end
    if (op == vec_pkg::VEXTRACT && scalar < vec_pkg::elem_t'(vl)) begin
      acc = model_rf[vs1][int'(scalar)];
    end
    return acc;
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  task automatic elem_check(input string name, input vec_pkg::elem_t got,
                            input vec_pkg::elem_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Every done pulse consumes one expected entry
  always @(negedge clk) begin
    if (arst_n && done) begin
      nr_done++;
      if (exp_result_q.size() == 0) begin
        other_errs++;
        $display("Error at %0t: done_o pulsed with no command pending", $time);
      end else begin
        exp_res = exp_result_q.pop_front();
        exp_sc  = exp_scalar_q.pop_front();
        flag_check("result_valid_o", result_valid, exp_sc);
        if (exp_sc) begin
          elem_check("result_o", result, exp_res);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Poke raises cmd_valid again for one cycle while the unit is busy
  task automatic run_cmd(input vec_pkg::vec_op_e op, input vec_pkg::vreg_idx_t vd,
                         input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
                         input vec_pkg::vl_t vl, input vec_pkg::elem_t scalar, input logic poke);
    int unsigned lat;
    logic        seen;
    @(negedge clk);
    while (busy) @(negedge clk);
    exp_result_q.push_back(ref_exec(op, vd, vs1, vs2, vl, scalar));
    exp_scalar_q.push_back(op == vec_pkg::VREDSUM || op == vec_pkg::VEXTRACT);
    nr_issued++;
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_op     <= op;
    cmd_vd     <= vd;
    cmd_vs1    <= vs1;
    cmd_vs2    <= vs2;
    cmd_vl     <= vl;
    cmd_scalar <= scalar;
    // Accepting edge
    @(posedge clk);
    cmd_valid <= 1'b0;
    lat  = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      lat++;
      seen = done;
      if (!seen) begin
        @(posedge clk);
        cmd_valid <= poke && (lat == 1);
        if (poke && lat == 1) begin
          cmd_op     <= vec_pkg::VSPLAT;
          cmd_vl     <= vec_pkg::vl_t'(vec_pkg::VLEN_ELEMS);
          cmd_scalar <= ~scalar;
        end
      end
    end
    if (lat != vec_pkg::PIPE_LATENCY) begin
      other_errs++;
      $display("Error at %0t: done_o came %0d cycles after acceptance instead of %0d",
               $time, lat, vec_pkg::PIPE_LATENCY);
    end
    @(negedge clk);
    flag_check("done_o", done, 1'b0);
    flag_check("busy_o", busy, 1'b0);
  endtask

  // Reads back all elements of one register through extracts
  task automatic check_vreg(input vec_pkg::vreg_idx_t r);
    for (int e = 0; e < vec_pkg::VLEN_ELEMS; e++) begin
      run_cmd(vec_pkg::VEXTRACT, '0, r, '0, vec_pkg::vl_t'(vec_pkg::VLEN_ELEMS),
              vec_pkg::elem_t'(e), 1'b0);
    end
  endtask

  initial begin
    vec_pkg::vec_op_e   op;
    vec_pkg::vl_t       vl;
    vec_pkg::elem_t     scalar;
    void'($urandom(11009));
    cmd_valid  <= 1'b0;
    cmd_op     <= vec_pkg::VSPLAT;
    cmd_vd     <= '0;
    cmd_vs1    <= '0;
    cmd_vs2    <= '0;
    cmd_vl     <= '0;
    cmd_scalar <= '0;
    for (int r = 0; r < vec_pkg::NR_VREGS; r++) begin
      for (int e = 0; e < vec_pkg::VLEN_ELEMS; e++) begin
        model_rf[r][e] = '0;
      end
    end
    wait (arst_n === 1'b1);
    @(negedge clk);

    // Reset state
    flag_check("busy_o", busy, 1'b0);
    flag_check("done_o", done, 1'b0);
    flag_check("result_valid_o", result_valid, 1'b0);
    elem_check("result_o", result, '0);
    for (int r = 0; r < vec_pkg::NR_VREGS; r++) begin
      run_cmd(vec_pkg::VEXTRACT, '0, vec_pkg::vreg_idx_t'(r), '0, 5'd16,
              vec_pkg::elem_t'($urandom_range(0, 15)), 1'b0);
    end

    // Splat with full and partial length, indices at and past vl
    run_cmd(vec_pkg::VSPLAT, 3'd1, '0, '0, 5'd16, 16'h5a5a, 1'b0);
    check_vreg(3'd1);
    run_cmd(vec_pkg::VSPLAT, 3'd1, '0, '0, 5'd5, 16'h0f0f, 1'b0);
    check_vreg(3'd1);
    run_cmd(vec_pkg::VEXTRACT, '0, 3'd1, '0, 5'd8, 16'd8, 1'b0);
    run_cmd(vec_pkg::VEXTRACT, '0, 3'd1, '0, 5'd3, 16'd20, 1'b0);

    // Element-wise adds near the top of the range
    run_cmd(vec_pkg::VSPLAT, 3'd2, '0, '0, 5'd16, 16'hfff0, 1'b0);
    run_cmd(vec_pkg::VSPLAT, 3'd3, '0, '0, 5'd16, 16'h0025, 1'b0);
    run_cmd(vec_pkg::VSPLAT, 3'd4, '0, '0, 5'd16, 16'h1234, 1'b0);
    run_cmd(vec_pkg::VADD, 3'd4, 3'd2, 3'd3, 5'd10, '0, 1'b0);
    check_vreg(3'd4);
    run_cmd(vec_pkg::VSPLAT, 3'd5, '0, '0, 5'd16, 16'h4321, 1'b0);
    run_cmd(vec_pkg::VADDS, 3'd5, 3'd2, '0, 5'd13, 16'h0011, 1'b0);
    check_vreg(3'd5);
    run_cmd(vec_pkg::VADDS, 3'd3, 3'd3, '0, 5'd16, 16'hffff, 1'b0);
    check_vreg(3'd3);

    // Reductions, empty and full length among them
    run_cmd(vec_pkg::VSPLAT, 3'd6, '0, '0, 5'd16, 16'hc000, 1'b0);
    run_cmd(vec_pkg::VADD, 3'd6, 3'd6, 3'd4, 5'd7, '0, 1'b0);
    run_cmd(vec_pkg::VREDSUM, '0, 3'd6, '0, 5'd0, 16'hbeef, 1'b0);
    run_cmd(vec_pkg::VREDSUM, '0, 3'd6, '0, 5'd16, 16'hfff0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      run_cmd(vec_pkg::VREDSUM, '0, 3'd6, '0, vec_pkg::vl_t'($urandom_range(0, 16)),
              vec_pkg::elem_t'($urandom), 1'b0);
    end

    // Random mix over all operations
    for (int i = 0; i < 200; i++) begin
      op     = vec_pkg::vec_op_e'(3'($urandom_range(0, 4)));
      vl     = vec_pkg::vl_t'($urandom_range(0, 16));
      scalar = (op == vec_pkg::VEXTRACT) ? vec_pkg::elem_t'($urandom_range(0, 19))
                                         : vec_pkg::elem_t'($urandom);
      run_cmd(op, vec_pkg::vreg_idx_t'($urandom_range(0, 7)),
              vec_pkg::vreg_idx_t'($urandom_range(0, 7)),
              vec_pkg::vreg_idx_t'($urandom_range(0, 7)), vl, scalar, 1'b0);
    end

    // Second command while busy must be dropped
    run_cmd(vec_pkg::VADDS, 3'd7, 3'd2, '0, 5'd16, 16'h0003, 1'b1);
    check_vreg(3'd7);

    if (nr_done != nr_issued) begin
      other_errs++;
      $display("Error: %0d done pulses seen for %0d commands", nr_done, nr_issued);
    end
    $display("Commands: %0d, value errors: %0d, other errors: %0d",
             nr_issued, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sources.f
vec_pkg.sv
vec_sequencer.sv
vec_lane.sv
vec_reduce.sv
vec_unit.sv
vec_unit_checker.sv
tb_clkgen.sv
tb_vec_unit.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_vec_unit -f sources.f \
  && { ./obj_dir/Vtb_vec_unit > sim.log 2>&1 || true; } \
  && grep -q "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
